//--- compile.f
+incdir+hw
hw/intan_pkg.sv
hw/intan_spi_engine.sv
hw/intan_reply_check.sv
hw/intan_cmd_seq.sv
hw/intan_ctrl_top.sv
dv/intan_chip_model.sv
dv/intan_ctrl_properties.sv
dv/intan_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
    --top-module intan_ctrl_tb -o sim_intan

./obj_dir/sim_intan | tee sim.log

if grep -qF "*** PASSED ***" sim.log; then
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi

//--- dv/intan_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "intan_params.svh"

module intan_ctrl_tb
    import intan_pkg::*;
();

    // frames per scenario: check, conf, retry, disagreement
    localparam int FRAME_CYCLES   = 140;
    localparam int TEST_FRAMES    = 9 + 16 + 18 + 45;
    localparam int TIMEOUT_CYCLES = 4 * TEST_FRAMES * FRAME_CYCLES;

    logic      clk;
    logic      rst;
    logic      miso;
    logic      start_check;
    logic      start_conf;
    cfg_bank_t cfg;
    logic      cs;
    logic      sclk;
    logic      mosi;
    logic      check_done;
    logic      conf_done;
    dev_kind_t dev_kind;
    reg_byte_t chip_id;
    reg_byte_t num_amp;
    logic      corrupt_next;
    frame_t    last_frame;
    int        frame_count;
    int        errors;
    int        checks;
    int        cycles;
    int        seed;

    intan_ctrl_top UUT (
        .clk        (clk),
        .rst        (rst),
        .miso       (miso),
        .start_check(start_check),
        .start_conf (start_conf),
        .cfg        (cfg),
        .cs         (cs),
        .sclk       (sclk),
        .mosi       (mosi),
        .check_done (check_done),
        .conf_done  (conf_done),
        .dev_kind   (dev_kind)
    );

    intan_chip_model u_chip (
        .cs          (cs),
        .sclk        (sclk),
        .mosi        (mosi),
        .miso        (miso),
        .chip_id     (chip_id),
        .num_amp     (num_amp),
        .corrupt_next(corrupt_next),
        .last_frame  (last_frame),
        .frame_count (frame_count)
    );

    bind intan_ctrl_top intan_ctrl_properties u_props (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: no result after %0d cycles", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic release_request(input logic conf);
        @(posedge clk);
        if (conf) begin
            start_conf <= 1'b0;
        end else begin
            start_check <= 1'b0;
        end
        @(negedge clk);
        check_value(conf ? "conf_done" : "check_done", conf ? conf_done : check_done, 1);
        @(negedge clk);
        check_value(conf ? "conf_done" : "check_done", conf ? conf_done : check_done, 0);
    endtask

    task automatic run_identity(input int exp_frames, input dev_kind_t exp_kind,
                                input logic corrupt);
        int base;
        base = frame_count;
        @(posedge clk);
        start_check <= 1'b1;
        if (corrupt) begin
            // arm while the read of register 41 is on the wire
            while (frame_count - base < 1) @(negedge clk);
            @(posedge clk);
            corrupt_next <= 1'b1;
            while (frame_count - base < 2) @(negedge clk);
            @(posedge clk);
            corrupt_next <= 1'b0;
        end
        while (!check_done) @(negedge clk);
        check_value("frames to check_done", frame_count - base, exp_frames);
        check_value("dev_kind", dev_kind, exp_kind);
        release_request(1'b0);
    endtask

    task automatic run_config();
        int     base;
        int     k;
        frame_t exp_frame;
        base = frame_count;
        k    = 0;
        @(posedge clk);
        start_conf <= 1'b1;
        while (!conf_done) begin
            @(negedge clk);
            if (frame_count - base > k) begin
                if (k < `INTAN_NUM_CFG) begin
                    exp_frame = {`INTAN_CMD_WRITE, 6'(k), cfg[k]};
                    check_value("config frame", last_frame, exp_frame);
                end
                k++;
            end
        end
        check_value("frames to conf_done", frame_count - base, 16);
        release_request(1'b1);
    endtask

    task automatic run_disagreement();
        int   base;
        logic bad;
        base = frame_count;
        bad  = 1'b0;
        @(posedge clk);
        start_check <= 1'b1;
        while (frame_count - base < 45 && !bad) begin
            @(negedge clk);
            // dev_kind holds the previous result until the first pass is judged
            if (check_done || (frame_count - base > 9 && dev_kind != 2'd0)) begin
                bad = 1'b1;
            end
        end
        check_value("check_done", check_done, 0);
        check_value("dev_kind", dev_kind, 0);
    endtask

    initial begin
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        seed         = 32'ha4f62aa3;
        rst          = 1'b1;
        start_check  = 1'b0;
        start_conf   = 1'b0;
        corrupt_next = 1'b0;
        chip_id      = 8'h01;
        num_amp      = 8'h20;
        for (int i = 0; i < `INTAN_NUM_CFG; i++) begin
            cfg[i] = 8'($random(seed));
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_value("cs", cs, 1);
        check_value("sclk", sclk, 0);
        repeat (10) begin
            @(negedge clk);
            check_value("check_done", check_done, 0);
            check_value("conf_done", conf_done, 0);
        end

        run_identity(9, 2'd2, 1'b0);
        run_config();
        run_identity(18, 2'd2, 1'b1);

        num_amp = 8'h40;
        run_disagreement();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/intan_ctrl_properties.sv
`timescale 1ns/1ps
`default_nettype none

module intan_ctrl_properties
    import intan_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      cs,
    input logic      sclk,
    input logic      start_check,
    input logic      start_conf,
    input logic      check_done,
    input logic      conf_done,
    input dev_kind_t dev_kind
);

    // sclk idles low between frames
    assert property (@(posedge clk) disable iff (rst) cs |-> !sclk)
        else $error("sclk high while cs is high");

    // done rises only while its request is held
    assert property (@(posedge clk) disable iff (rst) $rose(check_done) |-> start_check)
        else $error("check_done rose without start_check");

    assert property (@(posedge clk) disable iff (rst) $rose(conf_done) |-> start_conf)
        else $error("conf_done rose without start_conf");

    // done drops one cycle after its request
    assert property (@(posedge clk) disable iff (rst) check_done && !start_check |=> !check_done)
        else $error("check_done held after start_check dropped");

    assert property (@(posedge clk) disable iff (rst) conf_done && !start_conf |=> !conf_done)
        else $error("conf_done held after start_conf dropped");

    assert property (@(posedge clk) disable iff (rst) $rose(check_done) |-> dev_kind != 2'd0)
        else $error("check_done rose with unknown device kind");

endmodule

`default_nettype wire

//--- dv/intan_chip_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "intan_params.svh"

module intan_chip_model
    import intan_pkg::*;
(
    input  logic      cs,
    input  logic      sclk,
    input  logic      mosi,
    output logic      miso,
    input  reg_byte_t chip_id,
    input  reg_byte_t num_amp,
    input  logic      corrupt_next,
    output frame_t    last_frame,
    output int        frame_count
);

    frame_t rx;
    frame_t tx;
    // replies to the last frame and to the one before it
    frame_t reply_0;
    frame_t reply_1;
    frame_t next_reply;
    logic   armed;
    logic   in_frame;

    function automatic frame_t reply_for(input frame_t f);
        reg_addr_t addr;
        addr = f[13:8];
        if (f[15:14] == `INTAN_CMD_WRITE) begin
            return {`INTAN_RET_WRITE, f[7:0]};
        end
        case (addr)
            6'd40: return {`INTAN_RET_READ, `INTAN_TAG_0};
            6'd41: return {`INTAN_RET_READ, `INTAN_TAG_1};
            6'd42: return {`INTAN_RET_READ, `INTAN_TAG_2};
            6'd43: return {`INTAN_RET_READ, `INTAN_TAG_3};
            6'd44: return {`INTAN_RET_READ, `INTAN_TAG_4};
            `INTAN_REG_CHIPID: return {`INTAN_RET_READ, chip_id};
            `INTAN_REG_NUMAMP: return {`INTAN_RET_READ, num_amp};
            default: return {`INTAN_RET_READ, 8'h00};
        endcase
    endfunction

    initial begin
        miso        = 1'b0;
        rx          = '0;
        tx          = '0;
        reply_0     = '0;
        reply_1     = '0;
        armed       = 1'b0;
        in_frame    = 1'b0;
        last_frame  = '0;
        frame_count = 0;
    end

    always @(posedge corrupt_next) begin
        armed = 1'b1;
    end

    // reply to the frame two back goes out now
    always @(negedge cs) begin
        in_frame = 1'b1;
        tx       = reply_1;
        miso     = tx[`INTAN_FRAME_W-1];
    end

    always @(posedge sclk) begin
        if (!cs) begin
            rx = {rx[`INTAN_FRAME_W-2:0], mosi};
        end
    end

    always @(negedge sclk) begin
        if (!cs) begin
            tx   = tx << 1;
            miso = tx[`INTAN_FRAME_W-1];
        end
    end

    always @(posedge cs) begin
        if (in_frame) begin
            in_frame   = 1'b0;
            next_reply = reply_for(rx);
            if (armed) begin
                next_reply[7:0] = ~next_reply[7:0];
                armed           = 1'b0;
            end
            reply_1     = reply_0;
            reply_0     = next_reply;
            last_frame  = rx;
            frame_count = frame_count + 1;
        end
    end

endmodule

`default_nettype wire

//--- hw/intan_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module intan_ctrl_top
    import intan_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      miso,
    input  logic      start_check,
    input  logic      start_conf,
    input  cfg_bank_t cfg,
    output logic      cs,
    output logic      sclk,
    output logic      mosi,
    output logic      check_done,
    output logic      conf_done,
    output dev_kind_t dev_kind
);

    logic     cmd_valid;
    cmd_t     cmd;
    logic     credit_return;
    logic     rsp_valid;
    frame_t   rsp_word;
    expect_t  rsp_expect;
    logic     verdict_valid;
    verdict_t verdict;

    intan_cmd_seq u_seq (
        .clk          (clk),
        .rst          (rst),
        .start_check  (start_check),
        .start_conf   (start_conf),
        .cfg          (cfg),
        .credit_return(credit_return),
        .verdict_valid(verdict_valid),
        .verdict      (verdict),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .check_done   (check_done),
        .conf_done    (conf_done)
    );

    intan_spi_engine u_engine (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .miso         (miso),
        .credit_return(credit_return),
        .rsp_valid    (rsp_valid),
        .rsp_word     (rsp_word),
        .rsp_expect   (rsp_expect),
        .cs           (cs),
        .sclk         (sclk),
        .mosi         (mosi)
    );

    intan_reply_check u_check (
        .clk          (clk),
        .rst          (rst),
        .rsp_valid    (rsp_valid),
        .rsp_word     (rsp_word),
        .rsp_expect   (rsp_expect),
        .verdict_valid(verdict_valid),
        .verdict      (verdict),
        .dev_kind     (dev_kind)
    );

endmodule

`default_nettype wire

//--- hw/intan_cmd_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "intan_params.svh"

module intan_cmd_seq
    import intan_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start_check,
    input  logic      start_conf,
    input  cfg_bank_t cfg,
    input  logic      credit_return,
    input  logic      verdict_valid,
    input  verdict_t  verdict,
    output logic      cmd_valid,
    output cmd_t      cmd,
    output logic      check_done,
    output logic      conf_done
);

    // five tag reads, then chip id and amplifier count
    localparam logic [3:0] CHECK_LAST = 4'd6;
    localparam logic [3:0] CHIPID_STEP = 4'd5;
    localparam logic [3:0] CONF_LAST = 4'(`INTAN_NUM_CFG - 1);
    localparam logic [3:0] DRAIN_LAST = 4'(`INTAN_PIPE_DEPTH - 1);
    localparam logic [1:0] CREDITS_FULL = 2'(`INTAN_CMD_CREDITS);

    seq_state_t state;
    logic [3:0] step;
    logic [3:0] pass_last;
    logic [1:0] credits;
    logic       mode_conf;
    logic       fail_seen;
    logic       issue;
    logic       request;
    reg_addr_t  tag_addr;
    cmd_t       next_cmd;

    function automatic reg_byte_t tag_byte(input logic [3:0] idx);
        case (idx)
            4'd0: tag_byte = `INTAN_TAG_0;
            4'd1: tag_byte = `INTAN_TAG_1;
            4'd2: tag_byte = `INTAN_TAG_2;
            4'd3: tag_byte = `INTAN_TAG_3;
            default: tag_byte = `INTAN_TAG_4;
        endcase
    endfunction

    assign request   = mode_conf ? start_conf : start_check;
    assign pass_last = mode_conf ? CONF_LAST : CHECK_LAST;
    assign issue = (state == ST_CHECK || state == ST_CONF || state == ST_DRAIN) &&
                   credits != 2'd0;

    assign check_done = (state == ST_DONE) && !mode_conf;
    assign conf_done  = (state == ST_DONE) && mode_conf;

    // each command carries the expectation for its own reply
    always_comb begin
        tag_addr = `INTAN_REG_TAG0 + {2'b00, step};
        next_cmd = '0;
        // drain read, nothing to judge
        next_cmd.frame = {`INTAN_CMD_READ, `INTAN_REG_TAG0, `INTAN_RET_READ};
        case (state)
            ST_CHECK: begin
                if (step == CHIPID_STEP) begin
                    next_cmd.frame    = {`INTAN_CMD_READ, `INTAN_REG_CHIPID, `INTAN_RET_READ};
                    next_cmd.rec.kind = EXP_CHIPID;
                end else if (step == CHECK_LAST) begin
                    next_cmd.frame    = {`INTAN_CMD_READ, `INTAN_REG_NUMAMP, `INTAN_RET_READ};
                    next_cmd.rec.kind = EXP_NUMAMP;
                    next_cmd.rec.last = 1'b1;
                end else begin
                    next_cmd.frame    = {`INTAN_CMD_READ, tag_addr, `INTAN_RET_READ};
                    next_cmd.rec.kind = EXP_MATCH;
                    next_cmd.rec.word = {`INTAN_RET_READ, tag_byte(step)};
                end
            end
            ST_CONF: begin
                next_cmd.frame    = {`INTAN_CMD_WRITE, 2'b00, step, cfg[step]};
                next_cmd.rec.kind = EXP_MATCH;
                next_cmd.rec.word = {`INTAN_RET_WRITE, cfg[step]};
                next_cmd.rec.last = (step == CONF_LAST);
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_IDLE;
            step      <= '0;
            credits   <= CREDITS_FULL;
            mode_conf <= 1'b0;
            fail_seen <= 1'b0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= issue;
            credits   <= credits - 2'(issue) + 2'(credit_return);
            // a failed pass still runs to its end
            if (verdict_valid && !verdict.ok) begin
                fail_seen <= 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    step      <= '0;
                    fail_seen <= 1'b0;
                    if (start_check) begin
                        mode_conf <= 1'b0;
                        state     <= ST_CHECK;
                    end else if (start_conf) begin
                        mode_conf <= 1'b1;
                        state     <= ST_CONF;
                    end
                end
                ST_CHECK, ST_CONF: begin
                    if (issue) begin
                        if (step == pass_last) begin
                            step  <= '0;
                            state <= ST_DRAIN;
                        end else begin
                            step <= step + 4'd1;
                        end
                    end
                end
                ST_DRAIN: begin
                    if (issue) begin
                        if (step == DRAIN_LAST) begin
                            state <= ST_WAIT_VERDICT;
                        end else begin
                            step <= step + 4'd1;
                        end
                    end
                end
                ST_WAIT_VERDICT: begin
                    if (verdict_valid && verdict.ok && !fail_seen) begin
                        state <= ST_DONE;
                    end else if (fail_seen && credits == CREDITS_FULL) begin
                        // every frame of the bad pass is back, start over
                        fail_seen <= 1'b0;
                        step      <= '0;
                        state     <= mode_conf ? ST_CONF : ST_CHECK;
                    end
                end
                ST_DONE: begin
                    if (!request) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            cmd <= next_cmd;
        end
    end

endmodule

`default_nettype wire

//--- hw/intan_reply_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "intan_params.svh"

module intan_reply_check
    import intan_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rsp_valid,
    input  frame_t    rsp_word,
    input  expect_t   rsp_expect,
    output logic      verdict_valid,
    output verdict_t  verdict,
    output dev_kind_t dev_kind
);

    // oldest record sits at the top
    expect_t [`INTAN_PIPE_DEPTH-1:0] pipe;
    expect_t   rec;
    dev_kind_t word_kind;
    dev_kind_t id_kind;
    logic      bad;
    logic      kinds_agree;
    logic      ok;

    function automatic dev_kind_t decode_chip_id(input reg_byte_t b);
        case (b)
            8'h01: decode_chip_id = 2'd2;
            8'h02: decode_chip_id = 2'd1;
            8'h04: decode_chip_id = 2'd3;
            default: decode_chip_id = 2'd0;
        endcase
    endfunction

    function automatic dev_kind_t decode_num_amp(input reg_byte_t b);
        case (b)
            8'h10: decode_num_amp = 2'd1;
            8'h20: decode_num_amp = 2'd2;
            8'h40: decode_num_amp = 2'd3;
            default: decode_num_amp = 2'd0;
        endcase
    endfunction

    assign rec = pipe[`INTAN_PIPE_DEPTH-1];

    always_comb begin
        word_kind = '0;
        bad       = 1'b0;
        case (rec.kind)
            EXP_MATCH: begin
                bad = (rsp_word != rec.word);
            end
            EXP_CHIPID: begin
                word_kind = decode_chip_id(rsp_word[7:0]);
                bad       = (word_kind == '0);
            end
            EXP_NUMAMP: begin
                word_kind = decode_num_amp(rsp_word[7:0]);
                bad       = (word_kind == '0);
            end
            default: begin
            end
        endcase
    end

    // both decodes must name the same device
    assign kinds_agree = (rec.kind != EXP_NUMAMP) || (word_kind == id_kind);
    assign ok          = !bad && kinds_agree;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pipe          <= '0;
            id_kind       <= '0;
            dev_kind      <= '0;
            verdict_valid <= 1'b0;
        end else begin
            verdict_valid <= 1'b0;
            if (rsp_valid) begin
                if (rec.kind == EXP_CHIPID) begin
                    id_kind <= word_kind;
                end
                if (rec.last || bad) begin
                    verdict_valid <= 1'b1;
                    pipe          <= '0;
                    if (rec.last && rec.kind == EXP_NUMAMP) begin
                        dev_kind <= ok ? word_kind : 2'd0;
                    end
                end else begin
                    pipe <= {pipe[`INTAN_PIPE_DEPTH-2:0], rsp_expect};
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            verdict <= '{ok: ok, kind: word_kind};
        end
    end

endmodule

`default_nettype wire

//--- hw/intan_spi_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "intan_params.svh"

module intan_spi_engine
    import intan_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    cmd_valid,
    input  cmd_t    cmd,
    input  logic    miso,
    output logic    credit_return,
    output logic    rsp_valid,
    output frame_t  rsp_word,
    output expect_t rsp_expect,
    output logic    cs,
    output logic    sclk,
    output logic    mosi
);

    localparam int SLOT_W = $clog2(`INTAN_CMD_CREDITS);
    localparam int DIV_W = $clog2(`INTAN_SCLK_DIV);
    localparam int GAP_W = $clog2(`INTAN_CS_GAP);
    localparam int BIT_W = $clog2(`INTAN_FRAME_W);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`INTAN_SCLK_DIV - 1);
    localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(`INTAN_CS_GAP - 1);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`INTAN_FRAME_W - 1);

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_SHIFT,
        ENG_GAP
    } eng_state_t;

    eng_state_t       state;
    cmd_t             slots [`INTAN_CMD_CREDITS];
    logic [SLOT_W-1:0] wr_ptr;
    logic [SLOT_W-1:0] rd_ptr;
    logic [SLOT_W:0]  count;
    logic [DIV_W-1:0] div_cnt;
    logic [GAP_W-1:0] gap_cnt;
    logic [BIT_W-1:0] bit_cnt;
    frame_t           tx_sr;
    frame_t           rx_sr;
    logic             half_done;
    logic             rise;
    logic             fall;
    logic             pop;
    logic             gap_end;
    logic             start_frame;

    assign half_done   = (state == ENG_SHIFT) && (div_cnt == DIV_LAST);
    assign rise        = half_done && !sclk;
    assign fall        = half_done && sclk;
    // slot frees one cycle after cs rises
    assign pop         = (state == ENG_GAP) && (gap_cnt == '0);
    assign gap_end     = (state == ENG_GAP) && (gap_cnt == GAP_LAST);
    assign start_frame = (state == ENG_IDLE || gap_end) && (count != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= ENG_IDLE;
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            div_cnt       <= '0;
            gap_cnt       <= '0;
            bit_cnt       <= '0;
            cs            <= 1'b1;
            sclk          <= 1'b0;
            mosi          <= 1'b0;
            rsp_valid     <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            rsp_valid     <= pop;
            credit_return <= pop;
            count <= count + (SLOT_W + 1)'(cmd_valid) - (SLOT_W + 1)'(pop);
            if (cmd_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            if (start_frame) begin
                state   <= ENG_SHIFT;
                cs      <= 1'b0;
                div_cnt <= '0;
                bit_cnt <= '0;
                mosi    <= slots[rd_ptr].frame[`INTAN_FRAME_W-1];
            end else if (gap_end) begin
                state <= ENG_IDLE;
            end else if (state == ENG_GAP) begin
                gap_cnt <= gap_cnt + 1'b1;
            end else if (state == ENG_SHIFT) begin
                div_cnt <= div_cnt + 1'b1;
                if (half_done) begin
                    div_cnt <= '0;
                    sclk    <= !sclk;
                end
                if (fall) begin
                    if (bit_cnt == BIT_LAST) begin
                        cs      <= 1'b1;
                        gap_cnt <= '0;
                        state   <= ENG_GAP;
                    end else begin
                        // next bit goes out on the falling edge
                        bit_cnt <= bit_cnt + 1'b1;
                        mosi    <= tx_sr[`INTAN_FRAME_W-2];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            slots[wr_ptr] <= cmd;
        end
        if (start_frame) begin
            tx_sr <= slots[rd_ptr].frame;
        end else if (fall) begin
            tx_sr <= tx_sr << 1;
        end
        if (rise) begin
            rx_sr <= {rx_sr[`INTAN_FRAME_W-2:0], miso};
        end
        if (pop) begin
            rsp_word   <= rx_sr;
            rsp_expect <= slots[rd_ptr].rec;
        end
    end

endmodule

`default_nettype wire

//--- hw/intan_pkg.sv
`default_nettype none

`include "intan_params.svh"

package intan_pkg;

    typedef logic [`INTAN_FRAME_W-1:0] frame_t;
    typedef logic [5:0] reg_addr_t;
    typedef logic [7:0] reg_byte_t;

    // 0 unknown, 1 16ch, 2 32ch, 3 64ch
    typedef logic [1:0] dev_kind_t;

    typedef enum logic [1:0] {
        EXP_NONE,
        EXP_MATCH,
        EXP_CHIPID,
        EXP_NUMAMP
    } expect_kind_t;

    // what the reply to a command should look like
    typedef struct packed {
        expect_kind_t kind;
        frame_t       word;
        logic         last;
    } expect_t;

    typedef struct packed {
        frame_t  frame;
        expect_t rec;
    } cmd_t;

    typedef struct packed {
        logic      ok;
        dev_kind_t kind;
    } verdict_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CHECK,
        ST_CONF,
        ST_DRAIN,
        ST_WAIT_VERDICT,
        ST_DONE
    } seq_state_t;

    typedef reg_byte_t [`INTAN_NUM_CFG-1:0] cfg_bank_t;

endpackage

`default_nettype wire

//--- hw/intan_params.svh
`ifndef INTAN_PARAMS_SVH
`define INTAN_PARAMS_SVH

// frame layout {cmd[1:0], addr[5:0], data[7:0]}
`define INTAN_FRAME_W 16

`define INTAN_CMD_WRITE 2'b10
`define INTAN_CMD_READ 2'b11

// upper byte of the echoed reply
`define INTAN_RET_WRITE 8'hFF
`define INTAN_RET_READ 8'h00

`define INTAN_REG_TAG0 6'd40
`define INTAN_REG_CHIPID 6'd62
`define INTAN_REG_NUMAMP 6'd63

// company tag "INTAN" in registers 40 to 44
`define INTAN_TAG_0 8'h49
`define INTAN_TAG_1 8'h4E
`define INTAN_TAG_2 8'h54
`define INTAN_TAG_3 8'h41
`define INTAN_TAG_4 8'h4E

`define INTAN_NUM_CFG 14

`define INTAN_SCLK_DIV 4
`define INTAN_CS_GAP 4
`define INTAN_CMD_CREDITS 2
`define INTAN_PIPE_DEPTH 2

`endif
